// File: source/pcm_player.sv
`timescale 1ns/1ps

module pcm_player (
	input  logic pcm_clk,
	input  logic RESET,
	input  logic pcm_kick,

	output logic [snd_pkg::PCM_W-1:0] pcm_out,
	output logic pcm_busy
);
	import snd_pkg::*;

	logic kick_q;
	logic [PCM_ADDR_W-1:0] pcm_addr;
	logic [PCM_W-1:0] pcm_data;

	assign pcm_data = pcm_sample(pcm_addr);

	// pcm_busy doubles as the idle/playing state
	always_ff @(posedge pcm_clk or posedge RESET) begin
		if (RESET) begin
			kick_q   <= 1'b0;
			pcm_busy <= 1'b0;
			pcm_addr <= '0;
			pcm_out  <= '0;
		end else begin
			kick_q <= pcm_kick;
			if (pcm_busy) begin
				if (pcm_addr >= PCM_ADDR_W'(PCM_LEN)) begin
					pcm_busy <= 1'b0;  // last sample stays on pcm_out
				end else begin
					pcm_out  <= {1'b0, pcm_data[PCM_W-1:1]};  // half level
					pcm_addr <= pcm_addr + 1'b1;
				end
			end else begin
				// kicks only count here, a kick while playing is dropped
				pcm_busy <= kick_q;
				pcm_addr <= '0;
			end
		end
	end

endmodule

// File: source/snd_mixer.sv
`timescale 1ns/1ps

module snd_mixer (
	input  logic pcm_clk,
	input  logic RESET,
	input  logic [snd_pkg::SUM_W-1:0] wsg_sum,
	input  logic [snd_pkg::PCM_W-1:0] pcm_out,
	input  logic snd_enable,

	output logic [snd_pkg::SND_W-1:0] snd
);
	import snd_pkg::*;

	logic [SND_W:0] mix_sum;  // one carry bit for overflow

	// wavetable sum scaled down by 8
	assign mix_sum = wsg_sum[SUM_W-1 -: SND_W] + pcm_out;

	always_ff @(posedge pcm_clk or posedge RESET) begin
		if (RESET) begin
			snd <= '0;
		end else if (!snd_enable) begin
			snd <= '0;  // muted
		end else if (mix_sum[SND_W]) begin
			snd <= '1;  // clip at full scale
		end else begin
			snd <= mix_sum[SND_W-1:0];
		end
	end

endmodule

// File: source/snd_pkg.sv
package snd_pkg;

	// voice engine sizes
	localparam int NUM_VOICES  = 8;
	localparam int SLOT_W      = 3;
	localparam int FREQ_W      = 16;
	localparam int PHASE_W     = 20;  // wave index is the top WAVE_IDX_W bits
	localparam int WAVE_SEL_W  = 3;
	localparam int WAVE_IDX_W  = 5;
	localparam int WAVE_SAMP_W = 4;
	localparam int VOL_W       = 4;
	localparam int PROD_W      = WAVE_SAMP_W + VOL_W;
	localparam int SUM_W       = 11;  // 8 x 225 fits

	// pcm side
	localparam int PCM_LEN    = 256;
	localparam int PCM_ADDR_W = 9;  // must reach PCM_LEN itself
	localparam int PCM_W      = 8;
	localparam int SND_W      = 8;

	// host register window
	localparam int AXI_ADDR_W = 8;
	localparam int AXI_DATA_W = 32;

	localparam logic [AXI_ADDR_W-1:0] REG_VOICE_BASE = 8'h00;  // voice n at base + 4n
	localparam logic [AXI_ADDR_W-1:0] REG_CTRL       = 8'h20;  // bit 0 enable
	localparam logic [AXI_ADDR_W-1:0] REG_STATUS     = 8'h24;  // bit 0 pcm busy, read only

	// field positions inside a voice word, frequency sits at bit 0
	localparam int WAVE_LSB = 16;
	localparam int VOL_LSB  = 20;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// wave table contents, a ramp offset by the waveform number
	function automatic logic [WAVE_SAMP_W-1:0] wave_sample(
		input logic [WAVE_SEL_W-1:0] waveform,
		input logic [WAVE_IDX_W-1:0] index
	);
		logic [WAVE_IDX_W:0] total;
		total = index + waveform + 1'b1;
		return total[WAVE_SAMP_W-1:0];  // mod 16
	endfunction

	// pcm sample contents
	function automatic logic [PCM_W-1:0] pcm_sample(
		input logic [PCM_ADDR_W-1:0] address
	);
		return address[PCM_W-1:0] ^ 8'h5A;
	endfunction

endpackage

// File: source/snd_reg_bridge.sv
`timescale 1ns/1ps

module snd_reg_bridge (
	input  logic pcm_clk,
	input  logic RESET,

	input  logic [snd_pkg::AXI_ADDR_W-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [snd_pkg::AXI_DATA_W-1:0] wdata,
	input  logic [snd_pkg::AXI_DATA_W/8-1:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [snd_pkg::AXI_ADDR_W-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [snd_pkg::AXI_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,

	input  logic pcm_busy,

	output logic [snd_pkg::NUM_VOICES*snd_pkg::FREQ_W-1:0] voice_freq,
	output logic [snd_pkg::NUM_VOICES*snd_pkg::WAVE_SEL_W-1:0] voice_wave,
	output logic [snd_pkg::NUM_VOICES*snd_pkg::VOL_W-1:0] voice_vol,
	output logic [snd_pkg::NUM_VOICES-1:0] voice_wr,
	output logic snd_enable
);
	import snd_pkg::*;

	logic wr_go;
	logic rd_go;
	logic wr_voice;
	logic wr_ctrl;
	logic rd_voice;
	logic rd_ctrl;
	logic rd_status;
	logic [SLOT_W-1:0] wr_slot;
	logic [SLOT_W-1:0] rd_slot;
	logic [AXI_DATA_W-1:0] rd_word;
	logic rd_err;

	// address and data accepted together, only while no response is pending
	assign wr_go   = awvalid & wvalid & ~bvalid;
	assign awready = wr_go;
	assign wready  = wr_go;

	assign arready = ~rvalid;
	assign rd_go   = arvalid & arready;

	// word decode, low two address bits ignored
	assign wr_voice  = (awaddr[AXI_ADDR_W-1:SLOT_W+2] == REG_VOICE_BASE[AXI_ADDR_W-1:SLOT_W+2]);
	assign wr_ctrl   = (awaddr[AXI_ADDR_W-1:2] == REG_CTRL[AXI_ADDR_W-1:2]);
	assign wr_slot   = awaddr[SLOT_W+1:2];
	assign rd_voice  = (araddr[AXI_ADDR_W-1:SLOT_W+2] == REG_VOICE_BASE[AXI_ADDR_W-1:SLOT_W+2]);
	assign rd_ctrl   = (araddr[AXI_ADDR_W-1:2] == REG_CTRL[AXI_ADDR_W-1:2]);
	assign rd_status = (araddr[AXI_ADDR_W-1:2] == REG_STATUS[AXI_ADDR_W-1:2]);
	assign rd_slot   = araddr[SLOT_W+1:2];

	always_ff @(posedge pcm_clk or posedge RESET) begin
		if (RESET) begin
			voice_freq <= '0;
			voice_wave <= '0;
			voice_vol  <= '0;
			voice_wr   <= '0;
			snd_enable <= 1'b0;
			bvalid     <= 1'b0;
			bresp      <= RESP_OKAY;
		end else begin
			voice_wr <= '0;  // single cycle strobe
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (wr_go) begin
				bvalid <= 1'b1;
				bresp  <= (wr_voice || wr_ctrl) ? RESP_OKAY : RESP_SLVERR;
				if (wr_voice) begin
					if (wstrb[0])
						voice_freq[wr_slot*FREQ_W +: 8] <= wdata[7:0];
					if (wstrb[1])
						voice_freq[wr_slot*FREQ_W+8 +: 8] <= wdata[15:8];
					if (wstrb[2]) begin  // waveform and volume share byte 2
						voice_wave[wr_slot*WAVE_SEL_W +: WAVE_SEL_W] <= wdata[WAVE_LSB +: WAVE_SEL_W];
						voice_vol[wr_slot*VOL_W +: VOL_W] <= wdata[VOL_LSB +: VOL_W];
					end
					voice_wr[wr_slot] <= 1'b1;
				end
				if (wr_ctrl && wstrb[0])
					snd_enable <= wdata[0];
			end
		end
	end

	// read data, unused bits read as zero
	always_comb begin
		rd_word = '0;
		rd_err  = 1'b0;
		if (rd_voice) begin
			rd_word[FREQ_W-1:0]            = voice_freq[rd_slot*FREQ_W +: FREQ_W];
			rd_word[WAVE_LSB +: WAVE_SEL_W] = voice_wave[rd_slot*WAVE_SEL_W +: WAVE_SEL_W];
			rd_word[VOL_LSB +: VOL_W]       = voice_vol[rd_slot*VOL_W +: VOL_W];
		end else if (rd_ctrl) begin
			rd_word[0] = snd_enable;
		end else if (rd_status) begin
			rd_word[0] = pcm_busy;  // live player state
		end else begin
			rd_err = 1'b1;
		end
	end

	always_ff @(posedge pcm_clk or posedge RESET) begin
		if (RESET) begin
			rvalid <= 1'b0;
			rresp  <= RESP_OKAY;
		end else begin
			if (rvalid && rready)
				rvalid <= 1'b0;
			if (rd_go) begin
				rvalid <= 1'b1;
				rresp  <= rd_err ? RESP_SLVERR : RESP_OKAY;
			end
		end
	end

	always_ff @(posedge pcm_clk) begin
		if (rd_go)
			rdata <= rd_word;
	end

endmodule

// File: source/sound_top.sv
`timescale 1ns/1ps

module sound_top (
	input  logic pcm_clk,
	input  logic RESET,

	input  logic [snd_pkg::AXI_ADDR_W-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [snd_pkg::AXI_DATA_W-1:0] wdata,
	input  logic [snd_pkg::AXI_DATA_W/8-1:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [snd_pkg::AXI_ADDR_W-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [snd_pkg::AXI_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,

	input  logic pcm_kick,

	output logic [snd_pkg::SND_W-1:0] snd,
	output logic sample_tick
);
	import snd_pkg::*;

	// voice settings from the host window
	logic [NUM_VOICES*FREQ_W-1:0] voice_freq;
	logic [NUM_VOICES*WAVE_SEL_W-1:0] voice_wave;
	logic [NUM_VOICES*VOL_W-1:0] voice_vol;
	logic [NUM_VOICES-1:0] voice_wr;
	logic snd_enable;

	logic [SUM_W-1:0] wsg_sum;
	logic [PCM_W-1:0] pcm_out;
	logic pcm_busy;  // back to the status register

	// port names match the nets above
	snd_reg_bridge u_bridge (.*);

	wsg_voice_engine u_wsg (.*);

	pcm_player u_pcm (.*);

	snd_mixer u_mixer (.*);

endmodule

// File: source/wsg_voice_engine.sv
`timescale 1ns/1ps

module wsg_voice_engine (
	input  logic pcm_clk,
	input  logic RESET,

	input  logic [snd_pkg::NUM_VOICES*snd_pkg::FREQ_W-1:0] voice_freq,
	input  logic [snd_pkg::NUM_VOICES*snd_pkg::WAVE_SEL_W-1:0] voice_wave,
	input  logic [snd_pkg::NUM_VOICES*snd_pkg::VOL_W-1:0] voice_vol,
	input  logic [snd_pkg::NUM_VOICES-1:0] voice_wr,

	output logic [snd_pkg::SUM_W-1:0] wsg_sum,
	output logic sample_tick
);
	import snd_pkg::*;

	logic [SLOT_W-1:0] slot;
	logic frame_end;

	// settings frozen for one frame
	logic [FREQ_W-1:0] sh_freq [NUM_VOICES];
	logic [WAVE_SEL_W-1:0] sh_wave [NUM_VOICES];
	logic [VOL_W-1:0] sh_vol [NUM_VOICES];

	logic [PHASE_W-1:0] phase [NUM_VOICES];
	logic [NUM_VOICES-1:0] dirty;
	logic [NUM_VOICES-1:0] restart;
	logic [WAVE_IDX_W-1:0] cur_idx;

	logic [WAVE_SAMP_W-1:0] lk_samp;
	logic [VOL_W-1:0] lk_vol;
	logic [SLOT_W-1:0] lk_slot;
	logic [PROD_W-1:0] mul_prod;
	logic [SLOT_W-1:0] mul_slot;
	logic [SUM_W-1:0] acc;

	assign frame_end = (slot == SLOT_W'(NUM_VOICES-1));
	assign restart   = dirty | voice_wr;  // include a write landing on the latch edge
	assign cur_idx   = phase[slot][PHASE_W-1 -: WAVE_IDX_W];

	always_ff @(posedge pcm_clk or posedge RESET) begin
		if (RESET) begin
			slot  <= '0;
			dirty <= '0;
		end else begin
			slot <= slot + 1'b1;
			if (frame_end)
				dirty <= '0;
			else
				dirty <= dirty | voice_wr;
		end
	end

	// new settings take effect on entry to slot 0
	always_ff @(posedge pcm_clk or posedge RESET) begin
		if (RESET) begin
			for (int v = 0; v < NUM_VOICES; v++) begin
				sh_freq[v] <= '0;
				sh_wave[v] <= '0;
				sh_vol[v]  <= '0;
			end
		end else if (frame_end) begin
			for (int v = 0; v < NUM_VOICES; v++) begin
				sh_freq[v] <= voice_freq[v*FREQ_W +: FREQ_W];
				sh_wave[v] <= voice_wave[v*WAVE_SEL_W +: WAVE_SEL_W];
				sh_vol[v]  <= voice_vol[v*VOL_W +: VOL_W];
			end
		end
	end

	// one phase step per voice per frame, rewritten voices restart at 0
	always_ff @(posedge pcm_clk or posedge RESET) begin
		if (RESET) begin
			for (int v = 0; v < NUM_VOICES; v++)
				phase[v] <= '0;
		end else begin
			phase[slot] <= phase[slot] + PHASE_W'(sh_freq[slot]);
			if (frame_end) begin
				for (int v = 0; v < NUM_VOICES; v++)
					if (restart[v])
						phase[v] <= '0;
			end
		end
	end

	// lookup, multiply, accumulate
	always_ff @(posedge pcm_clk or posedge RESET) begin
		if (RESET) begin
			lk_samp     <= '0;
			lk_vol      <= '0;
			lk_slot     <= '0;
			mul_prod    <= '0;
			mul_slot    <= '0;
			acc         <= '0;
			wsg_sum     <= '0;
			sample_tick <= 1'b0;
		end else begin
			lk_samp <= wave_sample(sh_wave[slot], cur_idx);  // phase before this frame's step
			lk_vol  <= sh_vol[slot];
			lk_slot <= slot;

			mul_prod <= lk_samp * lk_vol;
			mul_slot <= lk_slot;

			if (mul_slot == '0)
				acc <= SUM_W'(mul_prod);  // first voice of the frame
			else
				acc <= acc + SUM_W'(mul_prod);

			sample_tick <= (mul_slot == SLOT_W'(NUM_VOICES-1));
			if (mul_slot == SLOT_W'(NUM_VOICES-1))
				wsg_sum <= acc + SUM_W'(mul_prod);  // held until next frame
		end
	end

endmodule

// File: tb/sound_checker.sv
`timescale 1ns/1ps

module sound_checker (
	input logic pcm_clk,
	input logic RESET,
	input logic awvalid,
	input logic wvalid,
	input logic awready,
	input logic wready,
	input logic [1:0] bresp,
	input logic bvalid,
	input logic bready,
	input logic [snd_pkg::AXI_DATA_W-1:0] rdata,
	input logic rvalid,
	input logic rready
);
	int unsigned fail_count = 0;  // watched by the testbench

	// responses stay up until the master takes them
	b_hold: assert property (@(posedge pcm_clk) disable iff (RESET)
		(bvalid && !bready) |=> bvalid)
		else begin $error("bvalid dropped before bready"); fail_count = fail_count + 1; end

	r_hold: assert property (@(posedge pcm_clk) disable iff (RESET)
		(rvalid && !rready) |=> rvalid)
		else begin $error("rvalid dropped before rready"); fail_count = fail_count + 1; end

	b_stable: assert property (@(posedge pcm_clk) disable iff (RESET)
		(bvalid && !bready) |=> $stable(bresp))
		else begin $error("bresp changed while valid"); fail_count = fail_count + 1; end

	r_stable: assert property (@(posedge pcm_clk) disable iff (RESET)
		(rvalid && !rready) |=> $stable(rdata))
		else begin $error("rdata changed while valid"); fail_count = fail_count + 1; end

	// address and data are only taken as a pair
	aw_pair: assert property (@(posedge pcm_clk) disable iff (RESET)
		awready |-> (awvalid && wvalid))
		else begin $error("awready without awvalid and wvalid"); fail_count = fail_count + 1; end

	w_pair: assert property (@(posedge pcm_clk) disable iff (RESET)
		wready |-> (awvalid && wvalid))
		else begin $error("wready without awvalid and wvalid"); fail_count = fail_count + 1; end

endmodule

bind snd_reg_bridge sound_checker proto_chk (
	.pcm_clk(pcm_clk), .RESET(RESET), .awvalid(awvalid), .wvalid(wvalid),
	.awready(awready), .wready(wready), .bresp(bresp), .bvalid(bvalid), .bready(bready),
	.rdata(rdata), .rvalid(rvalid), .rready(rready)
);

// File: tb/sound_tb.sv
`timescale 1ns/1ps

module sound_tb;
	import snd_pkg::*;

	logic pcm_clk;
	logic RESET;
	logic [AXI_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [AXI_DATA_W-1:0] wdata;
	logic [AXI_DATA_W/8-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [AXI_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [AXI_DATA_W-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic pcm_kick;
	logic [SND_W-1:0] snd;
	logic sample_tick;
	int unsigned cycle_count;

	sound_top dut_i (.*);

	initial pcm_clk = 1'b0;
	always #10 pcm_clk = ~pcm_clk;

	always @(posedge pcm_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= 20000)  // tests need roughly 2000
			abort_run("timeout, the tests did not finish within 20000 cycles");
	end

	always @(posedge pcm_clk)
		if (dut_i.u_bridge.proto_chk.fail_count != 0)
			abort_run("an AXI protocol assertion failed");

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input logic [AXI_DATA_W-1:0] got, exp);
		if (got !== exp)
			abort_run($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_resp(input string name, input logic [1:0] got, exp);
		if (got !== exp)
			abort_run($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_snd(input string name, input logic [SND_W-1:0] got, exp);
		if (got !== exp)
			abort_run($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	// reference contents, straight from the register map rules
	function automatic int ref_wave(input int wave, input int idx);
		return (idx + wave + 1) % 16;
	endfunction

	function automatic int ref_pcm_half(input int addr);
		return ((addr % 256) ^ 'h5A) >> 1;
	endfunction

	function automatic logic [SND_W-1:0] ref_mix(input int wsg_total, input int pcm);
		int s;
		s = wsg_total / 8 + pcm;
		if (s > 255)
			s = 255;  // clip
		return SND_W'(s);
	endfunction

	function automatic logic [AXI_DATA_W-1:0] voice_word(input int freq, input int wave, input int vol);
		return (vol << VOL_LSB) | (wave << WAVE_LSB) | freq;
	endfunction

	function automatic logic [AXI_ADDR_W-1:0] reg_addr(input int n);
		return (n < NUM_VOICES) ? REG_VOICE_BASE + AXI_ADDR_W'(4 * n) : REG_CTRL;
	endfunction

	function automatic logic [AXI_DATA_W-1:0] reg_mask(input int n);
		return (n < NUM_VOICES) ? 32'h00F7FFFF : 32'h1;
	endfunction

	task automatic next_cycle;
		@(posedge pcm_clk);
		#1;
	endtask

	// returns once snd reflects the new frame sum
	task automatic wait_tick;
		do next_cycle(); while (!sample_tick);
		next_cycle();
	endtask

	task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [AXI_DATA_W-1:0] data,
			input logic [AXI_DATA_W/8-1:0] strb, output logic [1:0] resp);
		logic taken;
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		do begin
			@(negedge pcm_clk);
			taken = awready;
			next_cycle();
		end while (!taken);
		awvalid = 1'b0;
		wvalid = 1'b0;
		repeat ($urandom % 4) next_cycle();
		bready = 1'b1;
		do begin
			@(negedge pcm_clk);
			taken = bvalid;
			resp = bresp;
			next_cycle();
		end while (!taken);
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, output logic [AXI_DATA_W-1:0] data,
			output logic [1:0] resp);
		logic taken;
		araddr = addr;
		arvalid = 1'b1;
		do begin
			@(negedge pcm_clk);
			taken = arready;
			next_cycle();
		end while (!taken);
		arvalid = 1'b0;
		repeat ($urandom % 4) next_cycle();
		rready = 1'b1;
		do begin
			@(negedge pcm_clk);
			taken = rvalid;
			data = rdata;
			resp = rresp;
			next_cycle();
		end while (!taken);
		rready = 1'b0;
	endtask

	task automatic write_ok(input logic [AXI_ADDR_W-1:0] addr, input logic [AXI_DATA_W-1:0] data);
		logic [1:0] resp;
		axi_write(addr, data, 4'hF, resp);
		check_resp("bresp", resp, RESP_OKAY);
	endtask

	task automatic read_check(input logic [AXI_ADDR_W-1:0] addr, input logic [AXI_DATA_W-1:0] exp,
			input logic [1:0] exp_resp);
		logic [AXI_DATA_W-1:0] data;
		logic [1:0] resp;
		axi_read(addr, data, resp);
		check_resp("rresp", resp, exp_resp);
		check_data("rdata", data, exp);
	endtask

	task automatic silence_voices;
		for (int v = 0; v < NUM_VOICES; v++)
			write_ok(reg_addr(v), voice_word(0, 0, 0));
	endtask

	// kick once, follow every sample, kick again mid way
	task automatic play_and_check(input int wsg_total);
		pcm_kick = 1'b1;
		next_cycle();
		pcm_kick = 1'b0;
		repeat (2) next_cycle();
		for (int a = 0; a < PCM_LEN; a++) begin
			next_cycle();
			check_snd("snd", snd, ref_mix(wsg_total, ref_pcm_half(a)));
			pcm_kick = (a == 100);  // must not restart playback
		end
		repeat (4) begin
			next_cycle();
			check_snd("snd", snd, ref_mix(wsg_total, ref_pcm_half(PCM_LEN - 1)));
		end
	endtask

	task automatic test_registers;
		logic [AXI_DATA_W-1:0] model [NUM_VOICES+1];
		logic [AXI_DATA_W-1:0] data;
		logic [1:0] resp;
		read_check(reg_addr(0), 0, RESP_OKAY);
		read_check(REG_STATUS, 0, RESP_OKAY);
		for (int n = 0; n <= NUM_VOICES; n++) begin
			data = $urandom;
			model[n] = data & reg_mask(n);
			write_ok(reg_addr(n), data);
		end
		for (int n = 0; n <= NUM_VOICES; n++)
			read_check(reg_addr(n), model[n], RESP_OKAY);
		for (int s = 1; s < 16; s += 3) begin  // byte strobes on voice 2
			data = $urandom;
			axi_write(reg_addr(2), data, 4'(s), resp);
			check_resp("bresp", resp, RESP_OKAY);
			for (int b = 0; b < 4; b++)
				if (s[b])
					model[2][8*b +: 8] = data[8*b +: 8];
			model[2] = model[2] & reg_mask(2);
			read_check(reg_addr(2), model[2], RESP_OKAY);
		end
		axi_write(8'h30, $urandom, 4'hF, resp);
		check_resp("bresp", resp, RESP_SLVERR);
		axi_write(REG_STATUS, 32'hFFFF_FFFF, 4'hF, resp);
		check_resp("bresp", resp, RESP_SLVERR);
		read_check(8'h30, 0, RESP_SLVERR);
		read_check(8'h28, 0, RESP_SLVERR);
		read_check(REG_CTRL, model[NUM_VOICES], RESP_OKAY);
	endtask

	task automatic test_static_tone;
		write_ok(REG_CTRL, 1);
		silence_voices();
		write_ok(reg_addr(3), voice_word(0, 5, 9));
		repeat (2) wait_tick();
		repeat (4) begin
			wait_tick();
			check_snd("snd", snd, ref_mix(ref_wave(5, 0) * 9, 0));
		end
	endtask

	task automatic test_stepping;
		bit found;
		silence_voices();
		write_ok(reg_addr(0), voice_word(16'h8000, 2, 15));
		found = 1'b0;
		for (int k = 0; k < 3 && !found; k++) begin
			wait_tick();
			found = (snd == ref_mix(ref_wave(2, 0) * 15, 0));
		end
		if (!found)
			abort_run("voice 0 did not start at wave index 0 within three ticks");
		for (int i = 1; i <= 40; i++) begin
			wait_tick();
			check_snd("snd", snd, ref_mix(ref_wave(2, i % 32) * 15, 0));
		end
	endtask

	task automatic test_pcm;
		logic [AXI_DATA_W-1:0] data;
		logic [1:0] resp;
		silence_voices();
		repeat (3) wait_tick();
		check_snd("snd", snd, 0);
		play_and_check(0);
		read_check(REG_STATUS, 0, RESP_OKAY);
		pcm_kick = 1'b1;
		next_cycle();
		pcm_kick = 1'b0;
		next_cycle();
		read_check(REG_STATUS, 1, RESP_OKAY);
		do axi_read(REG_STATUS, data, resp); while (data[0]);
	endtask

	// slow step, every voice parks on index 1 for 64 frames, loud enough to clip
	task automatic test_enable;
		int loud_total;
		bit found;
		loud_total = NUM_VOICES * ref_wave(7, 1) * 15;
		for (int v = 0; v < NUM_VOICES; v++)
			write_ok(reg_addr(v), voice_word(16'h0200, 7, 15));
		repeat (3) wait_tick();
		check_snd("snd", snd,
			ref_mix(NUM_VOICES * ref_wave(7, 0) * 15, ref_pcm_half(PCM_LEN - 1)));
		found = 1'b0;
		for (int k = 0; k < 80 && !found; k++) begin
			wait_tick();
			found = (snd == ref_mix(loud_total, ref_pcm_half(PCM_LEN - 1)));
		end
		if (!found)
			abort_run("the voices did not all reach wave index 1 within 80 ticks");
		play_and_check(loud_total);
		write_ok(REG_CTRL, 0);
		repeat (2) next_cycle();
		repeat (4) begin
			check_snd("snd", snd, 0);
			next_cycle();
		end
	endtask

	initial begin
		void'($urandom(32'h98410add));
		cycle_count = 0;
		RESET = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		pcm_kick = 1'b0;
		repeat (10) @(posedge pcm_clk);
		#1 RESET = 1'b0;
		if (!arready || awready || wready || bvalid || rvalid || sample_tick)
			abort_run("handshake outputs are not idle after reset");
		check_snd("snd", snd, 0);
		test_registers();
		test_static_tone();
		test_stepping();
		test_pcm();
		test_enable();
		next_cycle();
		if (dut_i.u_bridge.proto_chk.fail_count != 0) begin
			abort_run("an AXI protocol assertion failed");
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

// File: verilog.f
source/snd_pkg.sv
source/snd_reg_bridge.sv
source/wsg_voice_engine.sv
source/pcm_player.sv
source/snd_mixer.sv
source/sound_top.sv
tb/sound_checker.sv
tb/sound_tb.sv
